// File: eth_pkg.sv
// Ethernet, IPv4 and UDP definitions for the transport egress path
// Route struct from the return-address lookup and the IPv4 header layout

package eth_pkg;

  // -------------------------------------------------------------------
  // Return route carried on the CHDR tuser
  // -------------------------------------------------------------------

  // Destination MAC sits in the low bits, UDP port in the top bits
  typedef struct packed {
    logic [15:0] udp_dst;
    logic [31:0] ip_dst;
    logic [47:0] mac_dst;
  } route_t;

  // -------------------------------------------------------------------
  // Protocol constants
  // -------------------------------------------------------------------

  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
  // Version 4, IHL of five words, DSCP/ECN zero
  localparam logic [15:0] IP_VER_IHL_TOS = 16'h4500;
  // Don't-fragment only, fragment offset zero
  localparam logic [15:0] IP_FLAGS_DF = 16'h4000;
  localparam logic [7:0] IP_PROTO_UDP = 8'd17;

  // 20 bytes of IPv4 header plus 8 bytes of UDP header
  localparam logic [15:0] IP_UDP_OVERHEAD = 16'd28;
  localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

  // -------------------------------------------------------------------
  // IPv4 header, ten halfwords in wire order
  // -------------------------------------------------------------------

  // Checksum field is left at zero when the header is summed
  typedef struct packed {
    logic [15:0] ver_ihl_tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [15:0] flags_frag;
    logic [15:0] ttl_proto;
    logic [15:0] checksum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ip_hdr_t;

endpackage

// File: chdr_pkg.sv
// CHDR stream definitions shared by the framer, arbiter and interface

package chdr_pkg;

  // Data path width of the CHDR and MAC streams
  localparam int CHDR_W = 64;

  // Length field occupies bits 31:16 of the first CHDR word
  localparam int CHDR_LEN_LSB = 16;

  // Bit 3 is the error flag
  // Bits 2:0 count valid bytes in the last word, zero meaning all eight
  localparam int TUSER_W = 4;

  // Framer states, one per header word then the payload pass-through
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ETH_L0,
    ST_ETH_L1,
    ST_ETH_L2_IP_L0,
    ST_IP_L1,
    ST_IP_L2,
    ST_UDP,
    ST_PAYLOAD
  } frame_state_e;

endpackage

// File: stream_if.sv
// 64-bit AXI-Stream link with tuser and tlast between design blocks

`timescale 1ns/1ns

interface stream_if;
  import chdr_pkg::*;

  logic [CHDR_W-1:0]  tdata;
  logic [TUSER_W-1:0] tuser;
  logic               tlast;
  logic               tvalid;
  logic               tready;

  // Upstream side drives payload and valid
  modport src (
    output tdata, tuser, tlast, tvalid,
    input  tready
  );

  // Downstream side returns ready
  modport dst (
    input  tdata, tuser, tlast, tvalid,
    output tready
  );

endinterface

// File: ip_hdr_checksum.sv
// IPv4 header checksum
// Ones-complement sum of the ten header halfwords, registered and inverted

`timescale 1ns/1ns

module ip_hdr_checksum (
  input  logic             clk,
  input  eth_pkg::ip_hdr_t i_hdr,
  output logic [15:0]      o_checksum
);

  localparam int HALFWORDS = 10;
  localparam int HDR_BITS = 16 * HALFWORDS;

  logic [HDR_BITS-1:0] hdr_bits;
  // Ten halfwords fit in 20 bits without overflow
  logic [19:0]         sum;
  logic [16:0]         fold;
  logic [15:0]         folded;

  assign hdr_bits = i_hdr;

  always_comb begin
    sum = '0;
    for (int i = 0; i < HALFWORDS; i++) begin
      sum = sum + 20'(hdr_bits[16*i +: 16]);
    end
  end

  // End-around carry, two folds are enough
  assign fold = 17'(sum[15:0]) + 17'(sum[19:16]);
  // A carry out of the first fold leaves the low half small, so no third carry
  assign folded = fold[15:0] + 16'(fold[16]);

  always_ff @(posedge clk) begin
    o_checksum <= ~folded;
  end

endmodule

// File: udp_framer.sv
// Ethernet/IPv4/UDP framer
// Prepends six header words to each CHDR packet and marks trailing bytes

`timescale 1ns/1ns

module udp_framer #(
  parameter logic [7:0] IP_TTL = 8'd16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::CHDR_W-1:0] i_chdr_tdata,
  input  eth_pkg::route_t             i_route,
  input  logic                        i_chdr_tlast,
  input  logic                        i_chdr_tvalid,
  output logic                        o_chdr_tready,
  input  logic [47:0]                 i_my_eth_addr,
  input  logic [31:0]                 i_my_ipv4_addr,
  input  logic [15:0]                 i_my_udp_port,
  stream_if.src                       framed
);
  import eth_pkg::*;
  import chdr_pkg::*;

  frame_state_e state;
  logic [15:0]  chdr_len;
  route_t       route_q;
  ip_hdr_t      ip_hdr;
  logic [15:0]  ip_len;
  logic [15:0]  udp_len;
  logic [15:0]  ip_csum;

  // -------------------------------------------------------------------
  // Header state machine
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        // First word stays on the input until the payload phase
        ST_IDLE:         if (i_chdr_tvalid) state <= ST_ETH_L0;
        ST_ETH_L0:       if (framed.tready) state <= ST_ETH_L1;
        ST_ETH_L1:       if (framed.tready) state <= ST_ETH_L2_IP_L0;
        ST_ETH_L2_IP_L0: if (framed.tready) state <= ST_IP_L1;
        ST_IP_L1:        if (framed.tready) state <= ST_IP_L2;
        ST_IP_L2:        if (framed.tready) state <= ST_UDP;
        ST_UDP:          if (framed.tready) state <= ST_PAYLOAD;
        ST_PAYLOAD: begin
          if (i_chdr_tvalid && framed.tready && i_chdr_tlast) state <= ST_IDLE;
        end
        default:         state <= ST_IDLE;
      endcase
    end
  end

  // Length and route captured once per packet
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && i_chdr_tvalid) begin
      chdr_len <= i_chdr_tdata[CHDR_LEN_LSB +: 16];
      route_q  <= i_route;
    end
  end

  assign ip_len  = IP_UDP_OVERHEAD + chdr_len;
  assign udp_len = UDP_HDR_BYTES + chdr_len;

  // -------------------------------------------------------------------
  // IPv4 header checksum, ready well before ST_IP_L1
  // -------------------------------------------------------------------

  assign ip_hdr.ver_ihl_tos = IP_VER_IHL_TOS;
  assign ip_hdr.total_len   = ip_len;
  assign ip_hdr.ident       = '0;
  assign ip_hdr.flags_frag  = IP_FLAGS_DF;
  assign ip_hdr.ttl_proto   = {IP_TTL, IP_PROTO_UDP};
  assign ip_hdr.checksum    = '0;
  assign ip_hdr.src_ip      = i_my_ipv4_addr;
  assign ip_hdr.dst_ip      = route_q.ip_dst;

  ip_hdr_checksum ip_csum_i (
    .clk        (clk),
    .i_hdr      (ip_hdr),
    .o_checksum (ip_csum)
  );

  // -------------------------------------------------------------------
  // Framed stream
  // -------------------------------------------------------------------

  always_comb begin
    case (state)
      // Six bytes of zero pad ahead of the destination MAC
      ST_ETH_L0:       framed.tdata = {48'h0, route_q.mac_dst[47:32]};
      ST_ETH_L1:       framed.tdata = {route_q.mac_dst[31:0], i_my_eth_addr[47:16]};
      ST_ETH_L2_IP_L0: framed.tdata = {i_my_eth_addr[15:0], ETH_TYPE_IPV4,
                                       IP_VER_IHL_TOS, ip_len};
      ST_IP_L1:        framed.tdata = {16'h0, IP_FLAGS_DF, IP_TTL, IP_PROTO_UDP, ip_csum};
      ST_IP_L2:        framed.tdata = {i_my_ipv4_addr, route_q.ip_dst};
      // UDP checksum left at zero
      ST_UDP:          framed.tdata = {i_my_udp_port, route_q.udp_dst, udp_len, 16'h0};
      default:         framed.tdata = i_chdr_tdata;
    endcase
  end

  // Header words are always valid, payload follows the input
  assign framed.tvalid = (state == ST_PAYLOAD) ? i_chdr_tvalid : (state != ST_IDLE);
  assign framed.tlast  = (state == ST_PAYLOAD) && i_chdr_tlast;
  // Trailing byte count on the last word only, error flag clear
  assign framed.tuser  = framed.tlast ? {1'b0, chdr_len[2:0]} : '0;
  assign o_chdr_tready = (state == ST_PAYLOAD) && framed.tready;

endmodule

// File: egress_arbiter.sv
// Egress arbiter
// Round-robin merge of framed CHDR and CPU frames, switched between packets

`timescale 1ns/1ns

module egress_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  stream_if.dst                        framed,
  input  logic [chdr_pkg::CHDR_W-1:0]  i_cpu_tdata,
  input  logic [chdr_pkg::TUSER_W-1:0] i_cpu_tuser,
  input  logic                         i_cpu_tlast,
  input  logic                         i_cpu_tvalid,
  output logic                         o_cpu_tready,
  output logic [chdr_pkg::CHDR_W-1:0]  o_mac_tdata,
  output logic [chdr_pkg::TUSER_W-1:0] o_mac_tuser,
  output logic                         o_mac_tlast,
  output logic                         o_mac_tvalid,
  input  logic                         i_mac_tready
);
  import chdr_pkg::*;

  logic               out_en;
  logic               in_pkt;
  logic               cur_cpu;
  logic               sel_cpu;
  logic               sel_valid;
  logic [CHDR_W-1:0]  sel_tdata;
  logic [TUSER_W-1:0] sel_tuser;
  logic               sel_tlast;
  logic               accept;
  logic               xfer;

  // -------------------------------------------------------------------
  // Source select
  // -------------------------------------------------------------------

  // cur_cpu is the source of the packet in flight, or the last one served
  always_comb begin
    if (in_pkt) begin
      sel_cpu = cur_cpu;
    end else if (framed.tvalid && i_cpu_tvalid) begin
      // Both waiting, so the other source gets its turn
      sel_cpu = ~cur_cpu;
    end else begin
      sel_cpu = i_cpu_tvalid;
    end
  end

  assign sel_valid = sel_cpu ? i_cpu_tvalid : framed.tvalid;
  assign sel_tdata = sel_cpu ? i_cpu_tdata  : framed.tdata;
  assign sel_tuser = sel_cpu ? i_cpu_tuser  : framed.tuser;
  assign sel_tlast = sel_cpu ? i_cpu_tlast  : framed.tlast;

  // Register loads when empty or draining this cycle
  assign accept = out_en && (!o_mac_tvalid || i_mac_tready);
  assign xfer   = accept && sel_valid;

  // Ready goes to the selected source only
  assign framed.tready = accept && !sel_cpu;
  assign o_cpu_tready  = accept && sel_cpu;

  // -------------------------------------------------------------------
  // Grant tracking and output register
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_en       <= 1'b0;
      in_pkt       <= 1'b0;
      cur_cpu      <= 1'b1;
      o_mac_tvalid <= 1'b0;
    end else begin
      // Holds all readies low for one cycle after reset
      out_en <= 1'b1;
      if (accept) o_mac_tvalid <= sel_valid;
      if (xfer) begin
        cur_cpu <= sel_cpu;
        in_pkt  <= !sel_tlast;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      o_mac_tdata <= sel_tdata;
      o_mac_tuser <= sel_tuser;
      o_mac_tlast <= sel_tlast;
    end
  end

endmodule

// File: xport_egress_top.sv
// Ethernet/IPv4/UDP transport egress
// Frames CHDR packets and merges them with CPU frames toward the MAC

`timescale 1ns/1ns

module xport_egress_top #(
  parameter logic [7:0] IP_TTL = 8'd16
) (
  input  logic                         clk,
  input  logic                         rst,
  // CHDR packets with the return route on tuser
  input  logic [chdr_pkg::CHDR_W-1:0]  i_chdr_tdata,
  input  logic [95:0]                  i_chdr_tuser,
  input  logic                         i_chdr_tlast,
  input  logic                         i_chdr_tvalid,
  output logic                         o_chdr_tready,
  // Raw Ethernet frames from the CPU
  input  logic [chdr_pkg::CHDR_W-1:0]  i_cpu_tdata,
  input  logic [chdr_pkg::TUSER_W-1:0] i_cpu_tuser,
  input  logic                         i_cpu_tlast,
  input  logic                         i_cpu_tvalid,
  output logic                         o_cpu_tready,
  // To the MAC
  output logic [chdr_pkg::CHDR_W-1:0]  o_mac_tdata,
  output logic [chdr_pkg::TUSER_W-1:0] o_mac_tuser,
  output logic                         o_mac_tlast,
  output logic                         o_mac_tvalid,
  input  logic                         i_mac_tready,
  // Local addresses
  input  logic [47:0]                  i_my_eth_addr,
  input  logic [31:0]                  i_my_ipv4_addr,
  input  logic [15:0]                  i_my_udp_port
);
  import eth_pkg::*;

  route_t chdr_route;

  stream_if framed_s ();

  // tuser layout is {udp_dst, ip_dst, mac_dst}
  assign chdr_route = i_chdr_tuser;

  udp_framer #(
    .IP_TTL (IP_TTL)
  ) framer_i (
    .clk            (clk),
    .rst            (rst),
    .i_chdr_tdata   (i_chdr_tdata),
    .i_route        (chdr_route),
    .i_chdr_tlast   (i_chdr_tlast),
    .i_chdr_tvalid  (i_chdr_tvalid),
    .o_chdr_tready  (o_chdr_tready),
    .i_my_eth_addr  (i_my_eth_addr),
    .i_my_ipv4_addr (i_my_ipv4_addr),
    .i_my_udp_port  (i_my_udp_port),
    .framed         (framed_s.src)
  );

  egress_arbiter arb_i (
    .clk          (clk),
    .rst          (rst),
    .framed       (framed_s.dst),
    .i_cpu_tdata  (i_cpu_tdata),
    .i_cpu_tuser  (i_cpu_tuser),
    .i_cpu_tlast  (i_cpu_tlast),
    .i_cpu_tvalid (i_cpu_tvalid),
    .o_cpu_tready (o_cpu_tready),
    .o_mac_tdata  (o_mac_tdata),
    .o_mac_tuser  (o_mac_tuser),
    .o_mac_tlast  (o_mac_tlast),
    .o_mac_tvalid (o_mac_tvalid),
    .i_mac_tready (i_mac_tready)
  );

endmodule

// File: tb_xport_egress.sv
// Testbench for the transport egress path
// Table of CHDR and CPU packets checked against a frame model under MAC back-pressure

`timescale 1ns/1ns

module tb_xport_egress;

  localparam logic [7:0]  TTL     = 8'd64;
  localparam logic [47:0] MY_MAC  = 48'h0080_2f12_3456;
  localparam logic [31:0] MY_IP   = 32'hc0a8_0a02;
  localparam logic [15:0] MY_PORT = 16'd49153;
  localparam int          N_ROWS  = 9;

  // One packet per row with its start counted in cycles after reset
  typedef struct packed {
    logic        cpu;
    logic [15:0] udp_dst;
    logic [31:0] ip_dst;
    logic [47:0] mac_dst;
    logic [7:0]  words;
    logic [15:0] len;
    logic [15:0] start;
  } pkt_row_t;

  logic        clk;
  logic        rst;
  logic [63:0] i_chdr_tdata;
  logic [95:0] i_chdr_tuser;
  logic        i_chdr_tlast;
  logic        i_chdr_tvalid;
  logic        o_chdr_tready;
  logic [63:0] i_cpu_tdata;
  logic [3:0]  i_cpu_tuser;
  logic        i_cpu_tlast;
  logic        i_cpu_tvalid;
  logic        o_cpu_tready;
  logic [63:0] o_mac_tdata;
  logic [3:0]  o_mac_tuser;
  logic        o_mac_tlast;
  logic        o_mac_tvalid;
  logic        i_mac_tready;
  logic [47:0] i_my_eth_addr;
  logic [31:0] i_my_ipv4_addr;
  logic [15:0] i_my_udp_port;

  pkt_row_t    tbl [N_ROWS];
  // Expected words as {tlast, tuser, tdata} in one queue per source
  logic [68:0] exp_chdr [$];
  logic [68:0] exp_cpu [$];
  int          cyc = 0;
  int          base_cyc = 0;
  int          total_words = 0;
  int          rx_words = 0;
  int          err_data = 0;
  int          err_proto = 0;
  // Output packet tracking for the alternation check
  logic        out_in_pkt = 1'b0;
  logic        out_src_cpu = 1'b0;
  logic        have_prev = 1'b0;
  logic        other_waited = 1'b0;

  xport_egress_top #(.IP_TTL(TTL)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Payload pattern with the CHDR length in bits 31:16 of word 0
  function automatic logic [63:0] pay_word(input int r, input int w);
    logic [63:0] d;
    d = {tbl[r].cpu ? 8'hc5 : 8'h3a, 8'(r), 16'(w),
         32'(r * 32'h0101_0107) ^ 32'(w * 32'h2468_ace1)};
    if (!tbl[r].cpu && w == 0) d[31:16] = tbl[r].len;
    return d;
  endfunction

  // RFC 791 header checksum with the ident and checksum fields at zero
  function automatic logic [15:0] ip_checksum(input logic [15:0] ip_len, input logic [31:0] dst);
    logic [31:0] s;
    s = 32'h4500 + ip_len + 32'h4000 + {TTL, 8'd17} + MY_IP[31:16] + MY_IP[15:0]
      + dst[31:16] + dst[15:0];
    while (s[31:16] != 0) s = s[15:0] + s[31:16];
    return ~s[15:0];
  endfunction

  // -------------------------------------------------------------------
  // Reference model
  // -------------------------------------------------------------------

  task automatic model_frame(input int r);
    pkt_row_t    p;
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic        last;
    p = tbl[r];
    ip_len  = 16'd28 + p.len;
    udp_len = 16'd8 + p.len;
    if (!p.cpu) begin
      // Pad, Ethernet, IPv4 and UDP header words in wire order
      exp_chdr.push_back({5'b0, 48'h0, p.mac_dst[47:32]});
      exp_chdr.push_back({5'b0, p.mac_dst[31:0], MY_MAC[47:16]});
      exp_chdr.push_back({5'b0, MY_MAC[15:0], 16'h0800, 16'h4500, ip_len});
      exp_chdr.push_back({5'b0, 16'h0, 16'h4000, TTL, 8'd17, ip_checksum(ip_len, p.ip_dst)});
      exp_chdr.push_back({5'b0, MY_IP, p.ip_dst});
      exp_chdr.push_back({5'b0, MY_PORT, p.udp_dst, udp_len, 16'h0});
      total_words += 6;
    end
    for (int w = 0; w < p.words; w++) begin
      last = (w == p.words - 1);
      if (p.cpu) exp_cpu.push_back({last, last ? p.len[3:0] : 4'h0, pay_word(r, w)});
      else exp_chdr.push_back({last, last ? {1'b0, p.len[2:0]} : 4'h0, pay_word(r, w)});
    end
    total_words += p.words;
  endtask

  // -------------------------------------------------------------------
  // Feeders
  // -------------------------------------------------------------------

  task automatic send_packet(input int r);
    for (int w = 0; w < tbl[r].words; w++) begin
      if (tbl[r].cpu) begin
        i_cpu_tdata  = pay_word(r, w);
        i_cpu_tuser  = (w == tbl[r].words - 1) ? tbl[r].len[3:0] : 4'h0;
        i_cpu_tlast  = (w == tbl[r].words - 1);
        i_cpu_tvalid = 1'b1;
      end else begin
        i_chdr_tdata  = pay_word(r, w);
        i_chdr_tuser  = {tbl[r].udp_dst, tbl[r].ip_dst, tbl[r].mac_dst};
        i_chdr_tlast  = (w == tbl[r].words - 1);
        i_chdr_tvalid = 1'b1;
      end
      @(posedge clk);
      while (!(tbl[r].cpu ? o_cpu_tready : o_chdr_tready)) @(posedge clk);
      #1;
    end
    if (tbl[r].cpu) i_cpu_tvalid = 1'b0;
    else i_chdr_tvalid = 1'b0;
  endtask

  task automatic feed_rows(input logic cpu);
    for (int r = 0; r < N_ROWS; r++) begin
      if (tbl[r].cpu == cpu) begin
        while (cyc - base_cyc < tbl[r].start) begin
          @(posedge clk);
          #1;
        end
        send_packet(r);
      end
    end
  endtask

  task automatic check_idle(input string when_s);
    assert (o_mac_tvalid === 1'b0 && o_chdr_tready === 1'b0 && o_cpu_tready === 1'b0) else begin
      err_proto++;
      $display("Error at %0t: valid or ready high %s", $time, when_s);
    end
  endtask

  // Random MAC back-pressure with ready about three cycles in four
  initial begin
    logic [31:0] rnd;
    rnd = 32'hff7d;
    i_mac_tready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rnd = xorshift(rnd);
      i_mac_tready = (rnd[1:0] != 2'b00);
    end
  end

  // -------------------------------------------------------------------
  // Output monitor
  // -------------------------------------------------------------------

  always @(posedge clk) begin
    logic [68:0] got;
    logic [68:0] want;
    logic        new_cpu;
    int          pending;
    if (!rst) begin
      // Other source waiting strictly inside a packet must win the next grant
      if (out_in_pkt && !(o_mac_tvalid && i_mac_tready && o_mac_tlast))
        if (out_src_cpu ? i_chdr_tvalid : i_cpu_tvalid) other_waited = 1'b1;
      if (o_mac_tvalid && i_mac_tready) begin
        got = {o_mac_tlast, o_mac_tuser, o_mac_tdata};
        if (!out_in_pkt) begin
          // Zero top bits and the expected MAC mark a framed CHDR packet
          new_cpu = !(o_mac_tdata[63:48] == 16'h0 && exp_chdr.size() != 0
                      && o_mac_tdata[15:0] == exp_chdr[0][15:0]);
          assert (!(have_prev && other_waited && new_cpu == out_src_cpu)) else begin
            err_proto++;
            $display("Packets did not alternate at %0t although the other source waited", $time);
          end
          out_src_cpu  = new_cpu;
          have_prev    = 1'b1;
          other_waited = 1'b0;
          out_in_pkt   = 1'b1;
        end
        pending = out_src_cpu ? exp_cpu.size() : exp_chdr.size();
        assert (pending != 0) else begin
          err_proto++;
          $display("Output word at %0t arrived with no frame left to match", $time);
        end
        if (pending != 0) begin
          if (out_src_cpu) want = exp_cpu.pop_front();
          else want = exp_chdr.pop_front();
          assert (got === want) else begin
            err_data++;
            $display("Error at %0t: %s word got last %b user %h data %h, expected %b %h %h",
                     $time, out_src_cpu ? "CPU" : "CHDR", got[68], got[67:64], got[63:0],
                     want[68], want[67:64], want[63:0]);
          end
        end
        rx_words++;
        if (o_mac_tlast) out_in_pkt = 1'b0;
      end
    end
  end

  // -------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------

  initial begin
    // cpu, udp_dst, ip_dst, mac_dst, words, CHDR length or CPU last tuser, start
    tbl[0] = '{1'b0, 16'd5000, 32'hc0a8_0a01, 48'h0211_2233_4455, 8'd4, 16'd29, 16'd0};
    tbl[1] = '{1'b1, 16'd0, 32'h0, 48'h0, 8'd3, 16'd5, 16'd0};
    tbl[2] = '{1'b0, 16'd5001, 32'hc0a8_0a07, 48'h02aa_bbcc_ddee, 8'd2, 16'd16, 16'd2};
    tbl[3] = '{1'b1, 16'd0, 32'h0, 48'h0, 8'd5, 16'd0, 16'd3};
    tbl[4] = '{1'b0, 16'd49153, 32'h0a00_0005, 48'h0a0b_0c0d_0e0f, 8'd1, 16'd8, 16'd4};
    // Error flag set on this CPU frame
    tbl[5] = '{1'b1, 16'd0, 32'h0, 48'h0, 8'd1, 16'd11, 16'd4};
    tbl[6] = '{1'b0, 16'hffff, 32'hffff_fffe, 48'hffff_ffff_ffff, 8'd6, 16'd47, 16'd60};
    tbl[7] = '{1'b1, 16'd0, 32'h0, 48'h0, 8'd2, 16'd7, 16'd200};
    tbl[8] = '{1'b0, 16'd1, 32'h0000_0001, 48'h0000_0000_0001, 8'd3, 16'd24, 16'd200};
    for (int r = 0; r < N_ROWS; r++) model_frame(r);

    rst            = 1'b1;
    i_chdr_tdata   = '0;
    i_chdr_tuser   = '0;
    i_chdr_tlast   = 1'b0;
    i_chdr_tvalid  = 1'b0;
    // First word of CPU row 1 already waits while reset is held
    i_cpu_tdata    = pay_word(1, 0);
    i_cpu_tuser    = (tbl[1].words == 1) ? tbl[1].len[3:0] : 4'h0;
    i_cpu_tlast    = (tbl[1].words == 1);
    i_cpu_tvalid   = 1'b1;
    i_my_eth_addr  = MY_MAC;
    i_my_ipv4_addr = MY_IP;
    i_my_udp_port  = MY_PORT;

    // Watchdog scaled to the table length
    fork
      begin
        repeat (20 * total_words + 1000) @(posedge clk);
        $display("Run timed out: %0d of %0d words received, %0d data errors, %0d protocol errors",
                 rx_words, total_words, err_data, err_proto);
        $display("*** FAILED ***");
        $finish;
      end
    join_none

    repeat (16) begin
      @(posedge clk);
      #1;
      check_idle("during reset");
    end
    rst = 1'b0;
    #1;
    check_idle("in the first cycle after reset");
    @(posedge clk);
    #1;
    base_cyc = cyc;

    fork
      feed_rows(1'b0);
      feed_rows(1'b1);
    join
    while (rx_words < total_words) @(posedge clk);
    repeat (20) @(posedge clk);
    assert (rx_words == total_words && exp_chdr.size() == 0 && exp_cpu.size() == 0) else begin
      err_proto++;
      $display("Word count mismatch: received %0d, table holds %0d", rx_words, total_words);
    end

    $display("Done: %0d of %0d words, %0d data errors, %0d protocol errors",
             rx_words, total_words, err_data, err_proto);
    if (err_data == 0 && err_proto == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: src.f
eth_pkg.sv
chdr_pkg.sv
stream_if.sv
ip_hdr_checksum.sv
udp_framer.sv
egress_arbiter.sv
xport_egress_top.sv
tb_xport_egress.sv

// File: Bender.yml
package:
  name: xport_egress

sources:
  - eth_pkg.sv
  - chdr_pkg.sv
  - stream_if.sv
  - ip_hdr_checksum.sv
  - udp_framer.sv
  - egress_arbiter.sv
  - xport_egress_top.sv
  - target: simulation
    files:
      - tb_xport_egress.sv
